//--- design/rob_cfg_pkg.sv
// sizing constants for the reorder buffer and its dispatch group
// compiled first, every other file refers to it by scoped name

`default_nettype none

package rob_cfg_pkg;

  // --------------------
  // dispatch group
  localparam int DISP_SIZE    = 4;   // lanes per group
  localparam int LANE_PC_STEP = 4;   // bytes between neighbouring lanes
  localparam int PC_W         = 32;

  // --------------------
  // buffer sizing
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;                 // entry index
  localparam int CMT_ID_W       = CMT_ENTRY_W + 1;   // index plus wrap bit

  localparam int CAUSE_W = 5;   // exception or interrupt code

endpackage

`default_nettype wire

//--- design/rob_types_pkg.sv
// cause encodings seen at commit, shared by the RTL and the testbench
// the cause word is one union read two ways, selected by o_commit_int_valid

`default_nettype none

package rob_types_pkg;

  // synchronous exceptions
  typedef enum logic [rob_cfg_pkg::CAUSE_W-1:0] {
    INST_ADDR_MISALIGN = 0,
    INST_ACC_FAULT     = 1,
    ILLEGAL_INST       = 2,
    BREAKPOINT         = 3,
    LOAD_ACC_FAULT     = 5,
    ECALL_M            = 11
  } except_t;

  // asynchronous interrupts
  typedef enum logic [rob_cfg_pkg::CAUSE_W-1:0] {
    SUPER_SOFT_INT       = 1,
    MACHINE_SOFT_INT     = 3,
    SUPER_TIMER_INT      = 5,
    MACHINE_TIMER_INT    = 7,
    SUPER_EXTERNAL_INT   = 9,
    MACHINE_EXTERNAL_INT = 11
  } int_code_t;

  // --------------------
  // commit cause word
  typedef union packed {
    except_t   exc;   // int_valid low
    int_code_t irq;   // int_valid high
  } cause_u;

endpackage

`default_nettype wire

//--- design/rob_ptr.sv
// in and out commit-id pointers of the reorder buffer
// in advances on dispatch, out on commit; msb of each id is the wrap bit
// free count is what the dispatcher checks before sending a group

`timescale 1ns/1ps
`default_nettype none

module rob_ptr (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_in_valid,    // group dispatched
  input  wire logic                            i_out_valid,   // head group committed
  output logic [rob_cfg_pkg::CMT_ID_W-1:0]     o_in_cmt_id,
  output logic [rob_cfg_pkg::CMT_ID_W-1:0]     o_out_cmt_id,
  output logic [rob_cfg_pkg::CMT_ENTRY_W:0]    o_free_count
);

  logic [rob_cfg_pkg::CMT_ENTRY_W:0] r_used;   // occupied entries

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_cmt_id  <= '0;
      o_out_cmt_id <= '0;
      r_used       <= '0;
    end else begin
      if (i_in_valid) begin
        o_in_cmt_id <= o_in_cmt_id + 1'b1;   // carry lands in the wrap bit
      end
      if (i_out_valid) begin
        o_out_cmt_id <= o_out_cmt_id + 1'b1;
      end
      case ({i_in_valid, i_out_valid})
        2'b10:   r_used <= r_used + 1'b1;
        2'b01:   r_used <= r_used - 1'b1;
        default: r_used <= r_used;   // idle, or one in and one out
      endcase
    end
  end

  assign o_free_count = (rob_cfg_pkg::CMT_ENTRY_W + 1)'(rob_cfg_pkg::CMT_ENTRY_SIZE) - r_used;

endmodule

`default_nettype wire

//--- design/rob_entry_array.sv
// storage of the dispatch groups in flight, one entry per group
// tracks lane completion from done reports and kills younger entries on flush
// the head entry is read out combinationally for the commit logic

`timescale 1ns/1ps
`default_nettype none

module rob_entry_array (
  input  wire logic                                        i_clk,
  input  wire logic                                        i_reset_n,
  // dispatch write
  input  wire logic                                        i_load_valid,
  input  wire logic [rob_cfg_pkg::CMT_ENTRY_W-1:0]         i_load_entry,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_disp_grp_id,
  input  wire logic [rob_cfg_pkg::PC_W-1:0]                i_disp_pc,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_disp_except_valid,
  input  wire rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] i_disp_except_code,
  // done report
  input  wire logic                                        i_done_valid,
  input  wire logic [rob_cfg_pkg::CMT_ID_W-1:0]            i_done_cmt_id,
  input  wire logic [$clog2(rob_cfg_pkg::DISP_SIZE)-1:0]   i_done_lane,
  input  wire logic                                        i_done_except_valid,
  input  wire rob_types_pkg::except_t                      i_done_except_code,
  input  wire logic                                        i_done_mispred,
  // head and commit
  input  wire logic [rob_cfg_pkg::CMT_ENTRY_W-1:0]         i_head_entry,
  input  wire logic                                        i_commit,
  input  wire logic                                        i_kill,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_head_grp_id,
  output logic [rob_cfg_pkg::PC_W-1:0]                     o_head_pc,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_head_except_valid,
  output rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] o_head_except_code,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_head_mispred,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_head_dead,
  output logic                                             o_head_done
);

  logic [rob_cfg_pkg::CMT_ENTRY_SIZE-1:0] r_valid;
  logic [rob_cfg_pkg::CMT_ENTRY_SIZE-1:0] r_wrap;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]      r_grp_id    [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::PC_W-1:0]           r_pc        [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::DISP_SIZE-1:0]      r_done      [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::DISP_SIZE-1:0]      r_exc_valid [rob_cfg_pkg::CMT_ENTRY_SIZE];
  rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] r_exc_code [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::DISP_SIZE-1:0]      r_mispred   [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::DISP_SIZE-1:0]      r_dead      [rob_cfg_pkg::CMT_ENTRY_SIZE];
  logic [rob_cfg_pkg::CMT_ENTRY_SIZE-1:0] w_done_hit;   // report lands on entry
  logic [rob_cfg_pkg::CMT_ENTRY_SIZE-1:0] w_kill_hit;   // younger live entry

  // a report only counts when index and wrap bit both match
  always_comb begin
    for (int e = 0; e < rob_cfg_pkg::CMT_ENTRY_SIZE; e++) begin
      w_done_hit[e] = i_done_valid & r_valid[e] &
                      (r_wrap[e] == i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W]) &
                      (i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0] ==
                       rob_cfg_pkg::CMT_ENTRY_W'(e));
      w_kill_hit[e] = i_kill & r_valid[e] &
                      (i_head_entry != rob_cfg_pkg::CMT_ENTRY_W'(e));
    end
  end

  // --------------------
  // occupancy and wrap
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_wrap  <= '1;   // first load flips it to the in pointer's wrap of 0
    end else begin
      if (i_commit) begin
        r_valid[i_head_entry] <= 1'b0;
      end
      if (i_load_valid) begin
        r_valid[i_load_entry] <= 1'b1;
        r_wrap[i_load_entry]  <= ~r_wrap[i_load_entry];   // one reload per lap
      end
    end
  end

  // --------------------
  // group payload
  always_ff @(posedge i_clk) begin
    for (int e = 0; e < rob_cfg_pkg::CMT_ENTRY_SIZE; e++) begin
      if (w_kill_hit[e]) begin
        r_done[e] <= '1;
        r_dead[e] <= r_grp_id[e];
      end
    end
    if (|w_done_hit) begin
      r_done     [i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]][i_done_lane] <= 1'b1;
      r_exc_valid[i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]][i_done_lane] <=
        i_done_except_valid;
      r_exc_code [i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]][i_done_lane] <=
        i_done_except_code;
      r_mispred  [i_done_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]][i_done_lane] <= i_done_mispred;
    end
    if (i_load_valid) begin
      r_grp_id   [i_load_entry] <= i_disp_grp_id;
      r_pc       [i_load_entry] <= i_disp_pc;
      r_exc_valid[i_load_entry] <= i_disp_except_valid & i_disp_grp_id;
      r_exc_code [i_load_entry] <= i_disp_except_code;
      r_mispred  [i_load_entry] <= '0;
      // empty and pre-faulted lanes need no report
      r_done[i_load_entry] <= i_kill ? '1 : (~i_disp_grp_id | i_disp_except_valid);
      r_dead[i_load_entry] <= i_kill ? i_disp_grp_id : '0;   // dispatched into a flush
    end
  end

  // head read port
  assign o_head_grp_id       = r_grp_id[i_head_entry];
  assign o_head_pc           = r_pc[i_head_entry];
  assign o_head_except_valid = r_exc_valid[i_head_entry];
  assign o_head_except_code  = r_exc_code[i_head_entry];
  assign o_head_mispred      = r_mispred[i_head_entry];
  assign o_head_dead         = r_dead[i_head_entry];
  assign o_head_done         = r_valid[i_head_entry] & (&r_done[i_head_entry]);

endmodule

`default_nettype wire

//--- design/rob_commit_sel.sv
// commit decision for the head group, purely combinational
// picks the lowest live lane that redirects the pc, kills the lanes above it,
// and merges a pending interrupt into the cause and epc

`timescale 1ns/1ps
`default_nettype none

module rob_commit_sel (
  input  wire logic                                        i_head_done,
  input  wire logic [rob_cfg_pkg::CMT_ID_W-1:0]            i_head_cmt_id,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_head_grp_id,
  input  wire logic [rob_cfg_pkg::PC_W-1:0]                i_head_pc,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_head_except_valid,
  input  wire rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] i_head_except_code,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_head_mispred,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_head_dead,
  input  wire logic [5:0]                                  i_int_pending,  // [5] highest
  output logic                                             o_commit_valid,
  output logic [rob_cfg_pkg::CMT_ID_W-1:0]                 o_commit_cmt_id,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_commit_grp_id,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_commit_dead_id,
  output logic                                             o_commit_except_valid,
  output logic                                             o_commit_int_valid,
  output rob_types_pkg::cause_u                            o_commit_cause,
  output logic [rob_cfg_pkg::PC_W-1:0]                     o_commit_epc,
  output logic                                             o_commit_flush
);

  logic [rob_cfg_pkg::DISP_SIZE-1:0]         w_live;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]         w_redirect;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]         w_dead_new;   // lanes above the redirect
  logic [$clog2(rob_cfg_pkg::DISP_SIZE)-1:0] w_sel_lane;
  logic                                      w_sel_valid;
  logic                                      w_exc_sel;
  logic                                      w_int_take;
  rob_types_pkg::int_code_t                  w_int_code;

  assign w_live     = i_head_grp_id & ~i_head_dead;
  assign w_redirect = w_live & (i_head_except_valid | i_head_mispred);

  // --------------------
  // lane selection
  always_comb begin
    w_sel_lane  = '0;
    w_sel_valid = 1'b0;
    for (int l = rob_cfg_pkg::DISP_SIZE - 1; l >= 0; l--) begin
      if (w_redirect[l]) begin   // last hit is the lowest lane
        w_sel_lane  = ($clog2(rob_cfg_pkg::DISP_SIZE))'(l);
        w_sel_valid = 1'b1;
      end
    end
    for (int l = 0; l < rob_cfg_pkg::DISP_SIZE; l++) begin
      w_dead_new[l] = w_sel_valid & (l > w_sel_lane);
    end
  end

  assign w_exc_sel = w_sel_valid & i_head_except_valid[w_sel_lane];

  // --------------------
  // interrupt merge
  always_comb begin
    if (i_int_pending[5])      w_int_code = rob_types_pkg::MACHINE_EXTERNAL_INT;
    else if (i_int_pending[4]) w_int_code = rob_types_pkg::MACHINE_TIMER_INT;
    else if (i_int_pending[3]) w_int_code = rob_types_pkg::MACHINE_SOFT_INT;
    else if (i_int_pending[2]) w_int_code = rob_types_pkg::SUPER_EXTERNAL_INT;
    else if (i_int_pending[1]) w_int_code = rob_types_pkg::SUPER_TIMER_INT;
    else                       w_int_code = rob_types_pkg::SUPER_SOFT_INT;
  end

  // a fully dead group has no instruction to take the interrupt on
  assign w_int_take = (|i_int_pending) & (|w_live);

  always_comb begin
    o_commit_cause.exc = w_exc_sel ? i_head_except_code[w_sel_lane]
                                   : rob_types_pkg::INST_ADDR_MISALIGN;
    o_commit_epc = i_head_pc +
                   rob_cfg_pkg::PC_W'(w_sel_lane) * rob_cfg_pkg::PC_W'(rob_cfg_pkg::LANE_PC_STEP);
    if (w_int_take) begin
      o_commit_cause.irq = w_int_code;
      o_commit_epc       = i_head_pc;   // interrupt taken at the group start
    end
  end

  assign o_commit_valid        = i_head_done;
  assign o_commit_cmt_id       = i_head_cmt_id;
  assign o_commit_grp_id       = i_head_grp_id;
  assign o_commit_dead_id      = (i_head_dead | w_dead_new) & i_head_grp_id;
  assign o_commit_int_valid    = o_commit_valid & w_int_take;
  assign o_commit_except_valid = o_commit_valid & (w_exc_sel | w_int_take);
  assign o_commit_flush        = o_commit_except_valid;   // mispredict alone does not flush

endmodule

`default_nettype wire

//--- design/rob_top.sv
// reorder buffer top: pointers, entry storage and commit selection
// dispatch only while o_free_count is nonzero, one done report per cycle

`timescale 1ns/1ps
`default_nettype none

module rob_top (
  input  wire logic                                        i_clk,
  input  wire logic                                        i_reset_n,
  // dispatch
  input  wire logic                                        i_disp_valid,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_disp_grp_id,
  input  wire logic [rob_cfg_pkg::PC_W-1:0]                i_disp_pc,
  input  wire logic [rob_cfg_pkg::DISP_SIZE-1:0]           i_disp_except_valid,
  input  wire rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] i_disp_except_code,
  output logic [rob_cfg_pkg::CMT_ID_W-1:0]                 o_disp_cmt_id,
  output logic [rob_cfg_pkg::CMT_ENTRY_W:0]                o_free_count,
  // completion
  input  wire logic                                        i_done_valid,
  input  wire logic [rob_cfg_pkg::CMT_ID_W-1:0]            i_done_cmt_id,
  input  wire logic [$clog2(rob_cfg_pkg::DISP_SIZE)-1:0]   i_done_lane,
  input  wire logic                                        i_done_except_valid,
  input  wire rob_types_pkg::except_t                      i_done_except_code,
  input  wire logic                                        i_done_mispred,
  input  wire logic [5:0]                                  i_int_pending,
  // commit
  output logic                                             o_commit_valid,
  output logic [rob_cfg_pkg::CMT_ID_W-1:0]                 o_commit_cmt_id,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_commit_grp_id,
  output logic [rob_cfg_pkg::DISP_SIZE-1:0]                o_commit_dead_id,
  output logic                                             o_commit_except_valid,
  output logic                                             o_commit_int_valid,
  output rob_types_pkg::cause_u                            o_commit_cause,
  output logic [rob_cfg_pkg::PC_W-1:0]                     o_commit_epc,
  output logic                                             o_commit_flush
);

  logic [rob_cfg_pkg::CMT_ID_W-1:0]                    w_out_cmt_id;   // head id
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   w_head_grp_id;
  logic [rob_cfg_pkg::PC_W-1:0]                        w_head_pc;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   w_head_except_valid;
  rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] w_head_except_code;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   w_head_mispred;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   w_head_dead;
  logic                                                w_head_done;

  rob_ptr u_ptr (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_in_valid(i_disp_valid), .i_out_valid(o_commit_valid),
    .o_in_cmt_id(o_disp_cmt_id), .o_out_cmt_id(w_out_cmt_id),
    .o_free_count(o_free_count)
  );

  rob_entry_array u_entries (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_load_valid(i_disp_valid),
    .i_load_entry(o_disp_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]),
    .i_disp_grp_id(i_disp_grp_id), .i_disp_pc(i_disp_pc),
    .i_disp_except_valid(i_disp_except_valid), .i_disp_except_code(i_disp_except_code),
    .i_done_valid(i_done_valid), .i_done_cmt_id(i_done_cmt_id), .i_done_lane(i_done_lane),
    .i_done_except_valid(i_done_except_valid), .i_done_except_code(i_done_except_code),
    .i_done_mispred(i_done_mispred),
    .i_head_entry(w_out_cmt_id[rob_cfg_pkg::CMT_ENTRY_W-1:0]),
    .i_commit(o_commit_valid), .i_kill(o_commit_flush),
    .o_head_grp_id(w_head_grp_id), .o_head_pc(w_head_pc),
    .o_head_except_valid(w_head_except_valid), .o_head_except_code(w_head_except_code),
    .o_head_mispred(w_head_mispred), .o_head_dead(w_head_dead), .o_head_done(w_head_done)
  );

  rob_commit_sel u_commit_sel (
    .i_head_done(w_head_done), .i_head_cmt_id(w_out_cmt_id),
    .i_head_grp_id(w_head_grp_id), .i_head_pc(w_head_pc),
    .i_head_except_valid(w_head_except_valid), .i_head_except_code(w_head_except_code),
    .i_head_mispred(w_head_mispred), .i_head_dead(w_head_dead),
    .i_int_pending(i_int_pending),
    .o_commit_valid(o_commit_valid), .o_commit_cmt_id(o_commit_cmt_id),
    .o_commit_grp_id(o_commit_grp_id), .o_commit_dead_id(o_commit_dead_id),
    .o_commit_except_valid(o_commit_except_valid), .o_commit_int_valid(o_commit_int_valid),
    .o_commit_cause(o_commit_cause), .o_commit_epc(o_commit_epc),
    .o_commit_flush(o_commit_flush)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rob_model.svh
// reference model of the reorder buffer, included inside the testbench module
// keeps the groups in flight in dispatch order and predicts each commit

typedef struct {
  logic [rob_cfg_pkg::CMT_ID_W-1:0]                    id;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   grp;
  logic [rob_cfg_pkg::PC_W-1:0]                        pc;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   excv;
  rob_types_pkg::except_t [rob_cfg_pkg::DISP_SIZE-1:0] code;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   mis;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   done;
  logic [rob_cfg_pkg::DISP_SIZE-1:0]                   dead;
} grp_rec_t;

grp_rec_t                         model_q[$];   // oldest group at the front
logic [rob_cfg_pkg::CMT_ID_W-1:0] tail_id;

function automatic bit head_ready();
  if (model_q.size() == 0) return 1'b0;
  return &model_q[0].done;
endfunction

// pending bits in order: m ext, m timer, m soft, s ext, s timer, s soft
function automatic rob_types_pkg::int_code_t highest_int(input logic [5:0] pend);
  if (pend[5]) return rob_types_pkg::MACHINE_EXTERNAL_INT;
  if (pend[4]) return rob_types_pkg::MACHINE_TIMER_INT;
  if (pend[3]) return rob_types_pkg::MACHINE_SOFT_INT;
  if (pend[2]) return rob_types_pkg::SUPER_EXTERNAL_INT;
  if (pend[1]) return rob_types_pkg::SUPER_TIMER_INT;
  return rob_types_pkg::SUPER_SOFT_INT;
endfunction

task automatic predict_commit(input grp_rec_t g, input logic [5:0] pend,
                              output logic [3:0] e_dead, output logic e_exc,
                              output logic e_int, output logic [4:0] e_cause,
                              output logic [31:0] e_epc);
  logic [3:0] live;
  int         sel;
  live = g.grp & ~g.dead;
  sel  = -1;
  for (int l = 0; l < rob_cfg_pkg::DISP_SIZE; l++) begin
    if (sel < 0 && live[l] && (g.excv[l] || g.mis[l])) sel = l;   // lowest redirect
  end
  e_dead = g.dead & g.grp;
  for (int l = 0; l < rob_cfg_pkg::DISP_SIZE; l++) begin
    if (sel >= 0 && l > sel && g.grp[l]) e_dead[l] = 1'b1;
  end
  e_int   = (pend != 0) && (live != 0);
  e_exc   = e_int || (sel >= 0 && g.excv[sel]);
  e_cause = (sel >= 0) ? 5'(g.code[sel]) : 5'd0;
  e_epc   = g.pc + 32'(((sel >= 0) ? sel : 0) * 4);
  if (e_int) begin
    e_cause = 5'(highest_int(pend));
    e_epc   = g.pc;
  end
endtask

// flush turns every remaining group into an all-dead commit
task automatic kill_younger();
  grp_rec_t g;
  for (int i = 0; i < model_q.size(); i++) begin
    g      = model_q[i];
    g.dead = g.grp;
    g.done = '1;
    model_q[i] = g;
  end
endtask

//--- testbench/tb_rob.sv
// testbench for the reorder buffer top level
// random dispatch and done traffic from a fixed seed, each commit checked
// against the model in tb_rob_model.svh

`timescale 1ns/1ps
`default_nettype none

module tb_rob;

  localparam int RUN_CYCLES  = 2200;                 // all tests plus the drain
  localparam int WATCHDOG_NS = RUN_CYCLES * 4 + 400;

  logic i_clk;
  logic i_reset_n;
  logic i_disp_valid;
  logic [3:0] i_disp_grp_id;
  logic [31:0] i_disp_pc;
  logic [3:0] i_disp_except_valid;
  rob_types_pkg::except_t [3:0] i_disp_except_code;
  logic i_done_valid;
  logic [3:0] i_done_cmt_id;
  logic [1:0] i_done_lane;
  logic i_done_except_valid;
  rob_types_pkg::except_t i_done_except_code;
  logic i_done_mispred;
  logic [5:0] i_int_pending;
  logic [3:0] o_disp_cmt_id;
  logic [3:0] o_free_count;
  logic o_commit_valid;
  logic [3:0] o_commit_cmt_id;
  logic [3:0] o_commit_grp_id;
  logic [3:0] o_commit_dead_id;
  logic o_commit_except_valid;
  logic o_commit_int_valid;
  rob_types_pkg::cause_u o_commit_cause;
  logic [31:0] o_commit_epc;
  logic o_commit_flush;

  int err_count = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int n_commits = 0;
  int n_flush_disp = 0;   // dispatches that met a flushing commit

  `include "tb_rob_model.svh"

  // dispatch and report on the pins for one cycle, registered at the edge after
  grp_rec_t               disp_rec;
  bit                     disp_pend = 1'b0;
  bit                     rep_pend  = 1'b0;
  logic [3:0]             rep_id    = '0;
  logic [1:0]             rep_lane  = '0;
  logic                   rep_exc   = 1'b0;
  logic                   rep_mis   = 1'b0;
  rob_types_pkg::except_t rep_code  = rob_types_pkg::INST_ADDR_MISALIGN;

  rob_top DUT (.*);

  always #2 i_clk = ~i_clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, act);
      err_count++;
    end
  endtask

  function automatic rob_types_pkg::except_t rand_except();
    case ($urandom % 6)
      0:       return rob_types_pkg::INST_ADDR_MISALIGN;
      1:       return rob_types_pkg::INST_ACC_FAULT;
      2:       return rob_types_pkg::ILLEGAL_INST;
      3:       return rob_types_pkg::BREAKPOINT;
      4:       return rob_types_pkg::LOAD_ACC_FAULT;
      default: return rob_types_pkg::ECALL_M;
    endcase
  endfunction

  // random outstanding lane of a live group
  task automatic pick_report(output bit found, output int idx, output int lane);
    int cand_idx[$];
    int cand_lane[$];
    int k;
    for (int i = 0; i < model_q.size(); i++) begin
      for (int l = 0; l < 4; l++) begin
        if (model_q[i].grp[l] && !model_q[i].done[l]) begin
          cand_idx.push_back(i);
          cand_lane.push_back(l);
        end
      end
    end
    found = cand_idx.size() > 0;
    idx   = 0;
    lane  = 0;
    if (found) begin
      k    = $urandom % cand_idx.size();
      idx  = cand_idx[k];
      lane = cand_lane[k];
    end
  endtask

  // the pins of the current cycle land in the registers at the coming edge
  task automatic apply_pending_inputs(input bit killed);
    grp_rec_t g;
    if (rep_pend) begin
      for (int i = 0; i < model_q.size(); i++) begin
        if (model_q[i].id == rep_id) begin
          g                = model_q[i];
          g.done[rep_lane] = 1'b1;
          g.excv[rep_lane] = rep_exc;
          g.mis[rep_lane]  = rep_mis;
          g.code[rep_lane] = rep_code;
          model_q[i]       = g;
        end
      end
    end
    if (disp_pend) begin
      g = disp_rec;
      if (killed) begin   // dispatched into a flush
        g.dead = g.grp;
        g.done = '1;
        n_flush_disp++;
      end
      model_q.push_back(g);
      tail_id = tail_id + 1'b1;
    end
  endtask

  task automatic run_cycle(input int disp_pct, input int exc_pct, input int mis_pct,
                           input int pre_pct, input int done_pct, input bit int_on);
    grp_rec_t head;
    grp_rec_t g;
    logic [3:0] e_dead;
    logic e_exc;
    logic e_int;
    logic [4:0] e_cause;
    logic [31:0] e_epc;
    bit flush_now;
    bit found;
    int free_before;
    int idx;
    int lane;
    logic [5:0] pend_next;
    @(negedge i_clk);
    free_before = rob_cfg_pkg::CMT_ENTRY_SIZE - model_q.size();
    compare_field("o_free_count", free_before, o_free_count);
    compare_field("o_disp_cmt_id", tail_id, o_disp_cmt_id);
    compare_field("o_commit_valid", head_ready(), o_commit_valid);
    flush_now = 1'b0;
    if (head_ready()) begin
      head = model_q.pop_front();
      predict_commit(head, i_int_pending, e_dead, e_exc, e_int, e_cause, e_epc);
      compare_field("o_commit_cmt_id", head.id, o_commit_cmt_id);
      compare_field("o_commit_grp_id", head.grp, o_commit_grp_id);
      compare_field("o_commit_dead_id", e_dead, o_commit_dead_id);
      compare_field("o_commit_except_valid", e_exc, o_commit_except_valid);
      compare_field("o_commit_int_valid", e_int, o_commit_int_valid);
      compare_field("o_commit_flush", e_exc, o_commit_flush);
      if (e_exc) begin
        compare_field("o_commit_cause", e_cause, o_commit_cause);
        compare_field("o_commit_epc", e_epc, o_commit_epc);
      end
      flush_now = e_exc;
      if (flush_now) kill_younger();
      n_commits++;
    end
    apply_pending_inputs(flush_now);
    found = 1'b0;
    if ($urandom % 100 < done_pct) pick_report(found, idx, lane);
    rep_pend = found;
    if (found) begin
      g        = model_q[idx];
      rep_id   = g.id;
      rep_lane = 2'(lane);
      rep_exc  = ($urandom % 100) < exc_pct;
      rep_mis  = !rep_exc && (($urandom % 100) < mis_pct);
      rep_code = rand_except();
    end
    disp_pend = model_q.size() < rob_cfg_pkg::CMT_ENTRY_SIZE &&
                ($urandom % 100) < disp_pct;
    if (disp_pend) begin
      disp_rec.id   = tail_id;
      disp_rec.grp  = 4'($urandom % 15 + 1);
      disp_rec.pc   = $urandom & 32'hffff_fffc;
      disp_rec.mis  = '0;
      disp_rec.dead = '0;
      for (int l = 0; l < 4; l++) begin
        disp_rec.excv[l] = disp_rec.grp[l] && (($urandom % 100) < pre_pct);
        disp_rec.code[l] = rand_except();
      end
      disp_rec.done = ~disp_rec.grp | disp_rec.excv;   // pre-faulted lanes need no report
    end
    pend_next = i_int_pending;
    if (!int_on) pend_next = '0;
    else if ($urandom % 16 == 0) pend_next = 6'($urandom % 64);
    @(posedge i_clk);
    i_disp_valid        <= disp_pend;
    i_disp_grp_id       <= disp_rec.grp;
    i_disp_pc           <= disp_rec.pc;
    i_disp_except_valid <= disp_rec.excv;
    i_disp_except_code  <= disp_rec.code;
    i_done_valid        <= rep_pend;
    i_done_cmt_id       <= rep_id;
    i_done_lane         <= rep_lane;
    i_done_except_valid <= rep_exc;
    i_done_except_code  <= rep_code;
    i_done_mispred      <= rep_mis;
    i_int_pending       <= pend_next;
  endtask

  task automatic run_test(input string name, input int cycles, input int disp_pct,
                          input int exc_pct, input int mis_pct, input int pre_pct,
                          input bit int_on);
    int err_before;
    int cmt_before;
    int flush_before;
    err_before   = err_count;
    cmt_before   = n_commits;
    flush_before = n_flush_disp;
    repeat (cycles) run_cycle(disp_pct, exc_pct, mis_pct, pre_pct, 80, int_on);
    if (name == "flush_vs_dispatch" && n_flush_disp == flush_before) begin
      $display("no dispatch ever met a flushing commit");
      err_count++;
    end
    if (err_count == err_before) tests_ok++;
    else tests_bad++;
    $display("test %s: %0d commits, %0d errors", name, n_commits - cmt_before,
             err_count - err_before);
  endtask

  initial begin
    void'($urandom(32'h4b15));
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_disp_valid = 1'b0;
    i_disp_grp_id = '0;
    i_disp_pc = '0;
    i_disp_except_valid = '0;
    for (int l = 0; l < 4; l++) begin
      i_disp_except_code[l] = rob_types_pkg::INST_ADDR_MISALIGN;
    end
    i_done_valid = 1'b0;
    i_done_cmt_id = '0;
    i_done_lane = '0;
    i_done_except_valid = 1'b0;
    i_done_except_code = rob_types_pkg::INST_ADDR_MISALIGN;
    i_done_mispred = 1'b0;
    i_int_pending = '0;
    tail_id = '0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;
    // ----------------------
    run_test("empty_after_reset", 10, 0, 0, 0, 0, 1'b0);
    run_test("in_order", 300, 50, 0, 0, 0, 1'b0);
    run_test("exception", 300, 50, 10, 0, 0, 1'b0);
    run_test("mispredict", 300, 50, 0, 15, 5, 1'b0);
    run_test("interrupt", 300, 50, 0, 10, 0, 1'b1);
    run_test("flush_vs_dispatch", 300, 90, 20, 5, 5, 1'b0);
    // drain what is left
    for (int i = 0; i < 300 && (model_q.size() > 0 || disp_pend); i++) begin
      run_cycle(0, 0, 0, 0, 100, 1'b0);
    end
    if (model_q.size() != 0) begin
      $display("buffer did not drain, %0d groups left", model_q.size());
      err_count++;
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_count);
    if (err_count == 0 && tests_bad == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+testbench
design/rob_cfg_pkg.sv
design/rob_types_pkg.sv
design/rob_ptr.sv
design/rob_entry_array.sv
design/rob_commit_sel.sv
design/rob_top.sv
testbench/tb_rob.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log

verilator --binary --timing -f tb.f --top-module tb_rob -o tb_rob_sim > build.log 2>&1 \
  && ./obj_dir/tb_rob_sim > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
